/* logic/scope_pkg.sv */
// Scope package
// Shared widths, command codes, status constants and the records
// that pass between the command, acquisition and response blocks.

package scope_pkg;

	typedef logic signed [11:0] sample_t;   // adc sample
	typedef logic [9:0]         buf_addr_t; // ring buffer address
	typedef logic [15:0]        count16_t;  // event and sample counts
	typedef logic [7:0]         byte_t;
	typedef logic [31:0]        word_t;     // output stream word
	typedef logic [31:0]        length_t;   // readout length in bytes

	typedef enum logic [7:0] {
		TRIG_NONE    = 8'd0,
		TRIG_RISING  = 8'd1,
		TRIG_FALLING = 8'd2
	} trig_type_e;

	typedef enum logic [7:0] {
		CMD_READOUT    = 8'd0,
		CMD_ARM        = 8'd1,
		CMD_INFO       = 8'd2,
		CMD_TRIG_CFG   = 8'd8,
		CMD_DOWNSAMPLE = 8'd9
	} cmd_code_e;

	// b0 sits in the low byte, as it arrives first
	typedef struct packed {
		byte_t b7;
		byte_t b6;
		byte_t b5;
		byte_t b4;
		byte_t b3;
		byte_t b2;
		byte_t b1;
		byte_t b0; // command code
	} cmd_t;

	typedef struct packed {
		trig_type_e trig_type;
		sample_t    lower_thresh;
		sample_t    upper_thresh;
		byte_t      tot_count;      // time over threshold
		count16_t   length_to_take; // samples after trigger
		logic [4:0] downsample;     // keep one of 2^n
	} acq_cfg_t;

	typedef struct packed {
		count16_t  event_count;
		count16_t  post_count;
		buf_addr_t trig_addr;
	} acq_status_t;

	typedef struct packed {
		logic      readout;    // buffer readout instead of one word
		word_t     const_word;
		length_t   length;
		buf_addr_t start_addr;
	} resp_req_t;

	localparam word_t    FW_VERSION  = 32'd16;
	localparam count16_t STATUS_DONE = '1; // event complete marker

endpackage

/* logic/cmd_receiver.sv */
// Command receiver
// Packs eight stream bytes into one command and holds it
// until the decoder takes it.

`timescale 1ns/100ps

module cmd_receiver import scope_pkg::*; (
	input  logic  clk,
	input  logic  rstn,
	input  logic  i_tvalid,
	input  byte_t i_tdata,
	output logic  o_tready,
	output cmd_t  o_cmd,
	output logic  o_cmd_valid,
	input  logic  i_cmd_ready
);

	logic [2:0] byte_cnt;
	logic       byte_take;

	assign o_tready  = !o_cmd_valid; // stall while a command waits
	assign byte_take = i_tvalid && o_tready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt    <= '0;
			o_cmd_valid <= 1'b0;
		end else begin
			if (byte_take)
				byte_cnt <= byte_cnt + 3'd1; // wraps after b7
			if (byte_take && byte_cnt == 3'd7)
				o_cmd_valid <= 1'b1;
			else if (i_cmd_ready)
				o_cmd_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (byte_take)
			o_cmd[byte_cnt*8 +: 8] <= i_tdata;
	end

endmodule

/* logic/cmd_decoder.sv */
// Command decoder
// Interprets each command, keeps the acquisition settings and
// issues arm pulses and response requests to the streamer.

`timescale 1ns/100ps

module cmd_decoder import scope_pkg::*; (
	input  logic        clk,
	input  logic        rstn,
	input  cmd_t        i_cmd,
	input  logic        i_cmd_valid,
	output logic        o_cmd_ready,
	input  acq_status_t i_status,
	output acq_cfg_t    o_cfg,
	output logic        o_arm,
	output resp_req_t   o_req,
	output logic        o_req_valid,
	input  logic        i_req_ready
);

	buf_addr_t pretrig_offset;
	logic      cmd_take;
	logic      reply_en;
	resp_req_t reply;
	byte_t     lo_base;
	byte_t     hi_base;

	assign o_cmd_ready = i_req_ready && !o_req_valid;
	assign cmd_take    = i_cmd_valid && o_cmd_ready;

	// thresholds are base*16 + 8 truncated to 12 bits
	assign lo_base = i_cmd.b1 - i_cmd.b2 - 8'd128;
	assign hi_base = i_cmd.b1 + i_cmd.b2 - 8'd128;

	// ------------------------------
	// reply for the current command
	// ------------------------------
	always_comb begin
		reply_en         = 1'b1;
		reply.readout    = 1'b0;
		reply.const_word = '0;
		reply.length     = 32'd4;                                 // one status word
		reply.start_addr = i_status.trig_addr - pretrig_offset; // look back before trigger
		case (i_cmd.b0)
			CMD_READOUT: begin
				reply.readout = 1'b1;
				reply.length  = {i_cmd.b7, i_cmd.b6, i_cmd.b5, i_cmd.b4};
			end
			CMD_ARM:
				reply.const_word = {i_status.event_count, i_status.post_count};
			CMD_INFO: begin
				reply.const_word = FW_VERSION;
				reply_en         = (i_cmd.b1 == 8'd0); // only the version is known
			end
			CMD_TRIG_CFG, CMD_DOWNSAMPLE:
				reply.const_word = word_t'(i_cmd.b0); // echo the code
			default:
				reply_en = 1'b0; // unknown code gets no reply
		endcase
	end

	// ------------------------------
	// settings and handshakes
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_cfg          <= '0;
			pretrig_offset <= '0;
			o_arm          <= 1'b0;
			o_req_valid    <= 1'b0;
		end else begin
			o_arm <= cmd_take && (i_cmd.b0 == CMD_ARM);
			if (cmd_take)
				o_req_valid <= reply_en;
			else if (i_req_ready)
				o_req_valid <= 1'b0;
			if (cmd_take) begin
				case (i_cmd.b0)
					CMD_ARM: begin
						o_cfg.trig_type      <= trig_type_e'(i_cmd.b1);
						o_cfg.length_to_take <= {i_cmd.b5, i_cmd.b4};
					end
					CMD_TRIG_CFG: begin
						o_cfg.lower_thresh <= {lo_base, 4'h8};
						o_cfg.upper_thresh <= {hi_base, 4'h8};
						o_cfg.tot_count    <= i_cmd.b5;
						pretrig_offset     <= {i_cmd.b3[1:0], i_cmd.b4};
					end
					CMD_DOWNSAMPLE:
						o_cfg.downsample <= i_cmd.b1[4:0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_take && reply_en)
			o_req <= reply;
	end

endmodule

/* logic/acq_trigger.sv */
// Acquisition control
// Downsamples the incoming samples into the ring buffer, detects the
// trigger and counts the samples taken after it.

`timescale 1ns/100ps

module acq_trigger import scope_pkg::*; #(
	parameter int BUF_AW = 10
) (
	input  logic        clk,
	input  logic        rstn,
	input  logic        i_sample_valid,
	input  sample_t     i_sample,
	input  acq_cfg_t    i_cfg,
	input  logic        i_arm,
	input  logic        i_readout_done,
	output logic        o_wr_en,
	output buf_addr_t   o_wr_addr,
	output sample_t     o_wr_data,
	output acq_status_t o_status
);

	typedef enum logic [2:0] {
		ST_READY,
		ST_WAIT_PRE, // first trigger condition
		ST_WAIT_TOT, // time over threshold
		ST_CAPTURE,
		ST_DONE
	} acq_state_e;

	acq_state_e        state;
	logic [BUF_AW-1:0] wr_ptr;
	logic [BUF_AW-1:0] trig_addr;
	logic [30:0]       ds_cnt;
	logic [30:0]       ds_mask;
	logic              keep;
	logic              rising;
	logic              below_lo;
	logic              above_hi;
	logic              pre_met;
	logic              tot_met;
	byte_t             tot_cnt;
	count16_t          post_cnt;
	count16_t          post_next;
	count16_t          event_cnt;

	assign ds_mask = (31'd1 << i_cfg.downsample) - 31'd1;
	assign keep    = i_sample_valid && (state != ST_DONE) && (ds_cnt >= ds_mask);

	assign below_lo  = i_sample < i_cfg.lower_thresh;
	assign above_hi  = i_sample > i_cfg.upper_thresh;
	assign rising    = i_cfg.trig_type == TRIG_RISING;
	assign pre_met   = i_sample_valid && (rising ? below_lo : above_hi);
	assign tot_met   = i_sample_valid && (rising ? above_hi : below_lo);
	assign post_next = post_cnt + count16_t'(keep);

	assign o_status.event_count = event_cnt;
	assign o_status.post_count  = (state == ST_DONE) ? STATUS_DONE : post_cnt;
	assign o_status.trig_addr   = buf_addr_t'(trig_addr);

	// ------------------------------
	// buffer write side
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			ds_cnt  <= '0;
			wr_ptr  <= '0;
			o_wr_en <= 1'b0;
		end else begin
			o_wr_en <= keep;
			if (state == ST_DONE)
				ds_cnt <= '0; // restart phase on next event
			else if (i_sample_valid)
				ds_cnt <= keep ? '0 : ds_cnt + 31'd1;
			if (keep)
				wr_ptr <= wr_ptr + 1'b1; // wraps around the ring
		end
	end

	always_ff @(posedge clk) begin
		if (keep) begin
			o_wr_addr <= buf_addr_t'(wr_ptr);
			o_wr_data <= i_sample;
		end
	end

	// ------------------------------
	// trigger FSM
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state     <= ST_READY;
			trig_addr <= '0;
			tot_cnt   <= '0;
			post_cnt  <= '0;
			event_cnt <= '0;
		end else begin
			case (state)
				ST_READY: begin
					tot_cnt  <= '0;
					post_cnt <= '0;
					if (i_arm) begin
						if (rising || i_cfg.trig_type == TRIG_FALLING) begin
							state <= ST_WAIT_PRE;
						end else begin
							trig_addr <= wr_ptr; // immediate trigger
							state     <= ST_CAPTURE;
						end
					end
				end
				ST_WAIT_PRE:
					if (pre_met)
						state <= ST_WAIT_TOT;
				ST_WAIT_TOT: begin
					if (tot_met) begin
						tot_cnt <= tot_cnt + 8'd1;
						if (tot_cnt >= i_cfg.tot_count) begin
							trig_addr <= wr_ptr; // first sample at or after crossing
							state     <= ST_CAPTURE;
						end
					end
				end
				ST_CAPTURE: begin
					post_cnt <= post_next;
					if (post_next >= i_cfg.length_to_take) begin
						event_cnt <= event_cnt + 16'd1;
						state     <= ST_DONE;
					end
				end
				ST_DONE:
					if (i_readout_done)
						state <= ST_READY;
				default:
					state <= ST_READY;
			endcase
		end
	end

endmodule

/* logic/sample_buffer.sv */
// Sample ring buffer
// Dual-port RAM with one write port and a registered read port.

`timescale 1ns/100ps

module sample_buffer import scope_pkg::*; #(
	parameter int BUF_AW = 10
) (
	input  logic      clk,
	input  logic      i_wr_en,
	input  buf_addr_t i_wr_addr,
	input  sample_t   i_wr_data,
	input  buf_addr_t i_rd_addr,
	output sample_t   o_rd_data
);

	sample_t mem [2**BUF_AW];

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr[BUF_AW-1:0]] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr[BUF_AW-1:0]]; // one cycle read latency
	end

endmodule

/* logic/resp_streamer.sv */
// Response streamer
// Sends single status words and buffer readouts on the output stream,
// two samples per word, with keep and last from the remaining bytes.

`timescale 1ns/100ps

module resp_streamer import scope_pkg::*; #(
	parameter int BUF_AW = 10
) (
	input  logic       clk,
	input  logic       rstn,
	input  resp_req_t  i_req,
	input  logic       i_req_valid,
	output logic       o_req_ready,
	output buf_addr_t  o_rd_addr,
	input  sample_t    i_rd_data,
	output logic       o_readout_done,
	output logic       o_tvalid,
	output word_t      o_tdata,
	output logic [3:0] o_tkeep,
	output logic       o_tlast,
	input  logic       i_tready
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH, // first read address out
		ST_LOW,   // low sample arrives
		ST_HIGH,  // high sample arrives
		ST_SEND
	} tx_state_e;

	tx_state_e         state;
	logic              is_readout;
	length_t           remain;
	logic [BUF_AW-1:0] rd_addr;
	sample_t           lo_sample;
	logic              word_done;

	assign o_req_ready = (state == ST_IDLE);
	assign o_rd_addr   = buf_addr_t'(rd_addr);
	assign word_done   = o_tvalid && i_tready;

	// remain only changes on a transfer, so these hold while stalled
	assign o_tlast = (remain <= 32'd4);
	assign o_tkeep = (remain >= 32'd4) ? 4'b1111 : ~(4'b1111 << remain[1:0]);

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= ST_IDLE;
			is_readout     <= 1'b0;
			remain         <= '0;
			o_tvalid       <= 1'b0;
			o_readout_done <= 1'b0;
		end else begin
			o_readout_done <= word_done && o_tlast && is_readout;
			case (state)
				ST_IDLE: begin
					if (i_req_valid) begin
						is_readout <= i_req.readout;
						remain     <= i_req.length;
						o_tvalid   <= !i_req.readout; // status word goes out at once
						state      <= i_req.readout ? ST_FETCH : ST_SEND;
					end
				end
				ST_FETCH:
					state <= ST_LOW;
				ST_LOW:
					state <= ST_HIGH;
				ST_HIGH: begin
					o_tvalid <= 1'b1;
					state    <= ST_SEND;
				end
				ST_SEND: begin
					if (word_done) begin
						o_tvalid <= 1'b0;
						if (o_tlast) begin
							state <= ST_IDLE;
						end else begin
							remain <= remain - 32'd4;
							state  <= ST_LOW; // next sample already addressed
						end
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// ------------------------------
	// read address and word assembly
	// ------------------------------
	always_ff @(posedge clk) begin
		case (state)
			ST_IDLE: begin
				if (i_req_valid) begin
					rd_addr <= i_req.start_addr[BUF_AW-1:0];
					o_tdata <= i_req.const_word;
				end
			end
			ST_FETCH:
				rd_addr <= rd_addr + 1'b1;
			ST_LOW: begin
				lo_sample <= i_rd_data;
				rd_addr   <= rd_addr + 1'b1;
			end
			ST_HIGH:
				o_tdata <= {4'h0, i_rd_data, 4'h0, lo_sample};
			ST_SEND:
				if (word_done)
					rd_addr <= rd_addr + 1'b1; // wraps around the ring
			default: ;
		endcase
	end

endmodule

/* logic/scope_top.sv */
// Scope command core
// Command receiver and decoder, trigger and capture logic, sample
// ring buffer and the response stream back to the host.

`timescale 1ns/100ps

module scope_top import scope_pkg::*; #(
	parameter int BUF_AW = 10
) (
	input  logic       clk,
	input  logic       rstn,
	// command byte stream
	input  logic       i_tvalid,
	input  byte_t      i_tdata,
	output logic       o_tready,
	// response word stream
	output logic       o_tvalid,
	output word_t      o_tdata,
	output logic [3:0] o_tkeep,
	output logic       o_tlast,
	input  logic       i_tready,
	// adc samples
	input  logic       i_sample_valid,
	input  sample_t    i_sample
);

	cmd_t        cmd;
	logic        cmd_valid;
	logic        cmd_ready;
	acq_cfg_t    cfg;
	logic        arm;
	acq_status_t status;
	resp_req_t   req;
	logic        req_valid;
	logic        req_ready;
	logic        readout_done;
	logic        wr_en;
	buf_addr_t   wr_addr;
	sample_t     wr_data;
	buf_addr_t   rd_addr;
	sample_t     rd_data;

	cmd_receiver u_cmd_receiver (
		.clk         (clk),
		.rstn        (rstn),
		.i_tvalid    (i_tvalid),
		.i_tdata     (i_tdata),
		.o_tready    (o_tready),
		.o_cmd       (cmd),
		.o_cmd_valid (cmd_valid),
		.i_cmd_ready (cmd_ready)
	);

	cmd_decoder u_cmd_decoder (
		.clk         (clk),
		.rstn        (rstn),
		.i_cmd       (cmd),
		.i_cmd_valid (cmd_valid),
		.o_cmd_ready (cmd_ready),
		.i_status    (status),
		.o_cfg       (cfg),
		.o_arm       (arm),
		.o_req       (req),
		.o_req_valid (req_valid),
		.i_req_ready (req_ready)
	);

	acq_trigger #(.BUF_AW(BUF_AW)) u_acq_trigger (
		.clk            (clk),
		.rstn           (rstn),
		.i_sample_valid (i_sample_valid),
		.i_sample       (i_sample),
		.i_cfg          (cfg),
		.i_arm          (arm),
		.i_readout_done (readout_done),
		.o_wr_en        (wr_en),
		.o_wr_addr      (wr_addr),
		.o_wr_data      (wr_data),
		.o_status       (status)
	);

	sample_buffer #(.BUF_AW(BUF_AW)) u_sample_buffer (
		.clk       (clk),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	resp_streamer #(.BUF_AW(BUF_AW)) u_resp_streamer (
		.clk            (clk),
		.rstn           (rstn),
		.i_req          (req),
		.i_req_valid    (req_valid),
		.o_req_ready    (req_ready),
		.o_rd_addr      (rd_addr),
		.i_rd_data      (rd_data),
		.o_readout_done (readout_done),
		.o_tvalid       (o_tvalid),
		.o_tdata        (o_tdata),
		.o_tkeep        (o_tkeep),
		.o_tlast        (o_tlast),
		.i_tready       (i_tready)
	);

endmodule

/* verification/tb_clock.sv */
// Testbench clock and reset
// Free-running clock with reset held low for the first cycles.

`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD     = 4,
	parameter int RST_CYCLES = 10
) (
	output logic clk,
	output logic rstn
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rstn = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rstn = 1'b1; // release just after an edge
	end

endmodule

/* verification/tb_scope.sv */
// Scope core testbench
// Sends host commands, feeds ADC samples and checks the response
// stream against a model of the sample ring buffer.

`timescale 1ns/100ps

module tb_scope import scope_pkg::*; ();

	localparam int    CYCLE_LIMIT = 20000; // far above the few hundred cycles of the tests
	localparam int    WAIT_LIMIT  = 200;   // cycles allowed for one word
	localparam int    DEPTH       = 1024;
	localparam word_t VERSION_EXP = 32'd16;

	logic       clk;
	logic       rstn;
	logic       in_valid;
	byte_t      in_data;
	logic       in_ready;
	logic       out_valid;
	word_t      out_data;
	logic [3:0] out_keep;
	logic       out_last;
	logic       out_ready;
	logic       smp_valid;
	sample_t    smp_data;

	sample_t    model_mem [DEPTH]; // expected buffer contents
	sample_t    rx_samples [$];    // samples of the last readout
	int         model_ptr;
	int         model_phase;
	int         model_ds;
	int         events;
	int         cycles;
	int         errors;
	int         start_errors;
	int         tests_run;
	int         tests_failed;
	int         lo_level;
	int         hi_level;
	int         trig;
	int         seed_val;
	logic       ready_random;
	logic       quiet;

	tb_clock u_clock (
		.clk  (clk),
		.rstn (rstn)
	);

	scope_top u_dut (
		.clk            (clk),
		.rstn           (rstn),
		.i_tvalid       (in_valid),
		.i_tdata        (in_data),
		.o_tready       (in_ready),
		.o_tvalid       (out_valid),
		.o_tdata        (out_data),
		.o_tkeep        (out_keep),
		.o_tlast        (out_last),
		.i_tready       (out_ready),
		.i_sample_valid (smp_valid),
		.i_sample       (smp_data)
	);

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("sim failed");
			$finish;
		end
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic check_value(input string name, input word_t got, input word_t exp);
		assert (got === exp)
		else begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic cmd_t make_cmd(input byte_t code, input byte_t b1, input byte_t b2,
			input byte_t b3, input byte_t b4, input byte_t b5, input byte_t b6, input byte_t b7);
		cmd_t c;
		c.b0 = code;
		c.b1 = b1;
		c.b2 = b2;
		c.b3 = b3;
		c.b4 = b4;
		c.b5 = b5;
		c.b6 = b6;
		c.b7 = b7;
		return c;
	endfunction

	function automatic logic [3:0] keep_for(input int remain);
		return (remain >= 4) ? 4'b1111 : 4'((1 << remain) - 1);
	endfunction

	function automatic word_t byte_mask(input logic [3:0] keep);
		return {{8{keep[3]}}, {8{keep[2]}}, {8{keep[1]}}, {8{keep[0]}}};
	endfunction

	function automatic int wrap_addr(input int a);
		return ((a % DEPTH) + DEPTH) % DEPTH;
	endfunction

	task automatic send_cmd(input cmd_t c);
		logic taken;
		for (int i = 0; i < 8; i++) begin
			in_valid = 1'b1;
			in_data  = c[i*8 +: 8]; // b0 goes first
			taken    = 1'b0;
			while (!taken) begin
				taken = in_ready;
				@(posedge clk);
				#1;
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic recv_word(output word_t data, output logic [3:0] keep, output logic last,
			output logic got);
		int         waited;
		int         stalls;
		logic       stalled;
		word_t      held_data;
		logic [3:0] held_keep;
		logic       held_last;
		waited  = 0;
		stalls  = 0;
		stalled = 1'b0;
		got     = 1'b0;
		while (!got && waited < WAIT_LIMIT) begin
			if (stalled) begin // outputs must not move while stalled
				check_value("o_tvalid", out_valid, 1'b1);
				check_value("o_tdata", out_data, held_data);
				check_value("o_tkeep", out_keep, held_keep);
				check_value("o_tlast", out_last, held_last);
			end
			// random mode always holds off the first valid cycle
			out_ready = ready_random ? (stalls > 0 && $urandom % 2 == 0) : 1'b1;
			stalled   = out_valid && !out_ready;
			if (stalled)
				stalls++;
			held_data = out_data;
			held_keep = out_keep;
			held_last = out_last;
			if (out_valid && out_ready) begin
				got  = 1'b1;
				data = out_data;
				keep = out_keep;
				last = out_last;
			end
			@(posedge clk);
			#1;
			waited++;
		end
		out_ready = 1'b0;
		if (!got) begin
			$display("%0t ns: no response word within %0d cycles", $time, WAIT_LIMIT);
			errors++;
		end
	endtask

	task automatic status_reply(input word_t exp);
		word_t      data;
		logic [3:0] keep;
		logic       last;
		logic       got;
		recv_word(data, keep, last, got);
		if (got) begin
			check_value("o_tdata", data, exp);
			check_value("o_tkeep", keep, 4'b1111);
			check_value("o_tlast", last, 1'b1);
		end
	endtask

	// ------------------------------
	// command sequences
	// ------------------------------
	task automatic arm(input trig_type_e kind, input int len, input logic done_expected);
		send_cmd(make_cmd(CMD_ARM, kind, 8'd0, 8'd0, len[7:0], len[15:8], 8'd0, 8'd0));
		status_reply({events[15:0], done_expected ? 16'hffff : 16'h0000});
	endtask

	task automatic trig_cfg(input byte_t b1, input byte_t b2, input int off, input byte_t tot);
		send_cmd(make_cmd(CMD_TRIG_CFG, b1, b2, off[9:8], off[7:0], tot, 8'd0, 8'd0));
		status_reply(32'd8);
		lo_level = int'(sample_t'((int'(b1) - int'(b2) - 128) * 16 + 8)) - 100;
		hi_level = int'(sample_t'((int'(b1) + int'(b2) - 128) * 16 + 8)) + 100;
	endtask

	task automatic feed(input int value0, input int step, input int count);
		for (int n = 0; n < count; n++) begin
			smp_valid   = 1'b1;
			smp_data    = sample_t'(value0 + n * step);
			model_phase = model_phase + 1;
			if (model_phase == (1 << model_ds)) begin // one of 2^n stored
				model_mem[model_ptr] = smp_data;
				model_ptr            = wrap_addr(model_ptr + 1);
				model_phase          = 0;
			end
			@(posedge clk);
			#1;
		end
		smp_valid = 1'b0;
	endtask

	task automatic read_buffer(input int start, input int bytes);
		int         remain;
		int         addr;
		word_t      exp;
		word_t      mask;
		word_t      data;
		logic [3:0] keep;
		logic       last;
		logic       got;
		remain = bytes;
		addr   = start;
		rx_samples.delete();
		send_cmd(make_cmd(CMD_READOUT, 8'd0, 8'd0, 8'd0,
			bytes[7:0], bytes[15:8], bytes[23:16], bytes[31:24]));
		while (remain > 0) begin
			exp  = {4'h0, model_mem[wrap_addr(addr + 1)], 4'h0, model_mem[wrap_addr(addr)]};
			mask = byte_mask(keep_for(remain));
			recv_word(data, keep, last, got);
			if (!got)
				break;
			check_value("o_tdata", data & mask, exp & mask);
			check_value("o_tkeep", keep, keep_for(remain));
			check_value("o_tlast", last, remain <= 4);
			rx_samples.push_back(data[11:0]);
			if (remain > 2)
				rx_samples.push_back(data[27:16]);
			remain -= 4;
			addr   += 2;
		end
	endtask

	task automatic end_test(input string name);
		int n;
		n = errors - start_errors;
		tests_run++;
		if (n != 0)
			tests_failed++;
		$display("%-24s %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
		start_errors = errors;
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		in_valid     = 1'b0;
		in_data      = '0;
		out_ready    = 1'b0;
		smp_valid    = 1'b0;
		smp_data     = '0;
		ready_random = 1'b0;
		model_ptr    = 0;
		model_phase  = 0;
		model_ds     = 0;
		events       = 0;
		errors       = 0;
		start_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		seed_val     = $urandom(74);
		@(posedge rstn);
		@(posedge clk);
		#1;

		send_cmd(make_cmd(CMD_INFO, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0));
		status_reply(VERSION_EXP);
		end_test("version read");

		arm(TRIG_NONE, 8, 1'b0);
		trig = model_ptr;
		feed(-300, 37, 8);
		events++;
		arm(TRIG_NONE, 8, 1'b1); // ignored while done but still replies
		read_buffer(trig, 16);
		end_test("immediate trigger");

		trig_cfg(8'd128, 8'd16, 0, 8'd2);
		arm(TRIG_RISING, 6, 1'b0);
		feed(lo_level, 0, 4);
		feed(hi_level + 50, 0, 2); // over threshold, count not yet exceeded
		trig = model_ptr;          // third sample over threshold
		feed(hi_level, 0, 7);
		events++;
		arm(TRIG_RISING, 6, 1'b1);
		read_buffer(trig, 12);
		foreach (rx_samples[i])
			check_value("rising sample", word_t'(rx_samples[i]), word_t'(sample_t'(hi_level)));
		end_test("rising trigger");

		arm(TRIG_FALLING, 6, 1'b0);
		feed(hi_level, 0, 4);
		feed(lo_level - 50, 0, 2);
		trig = model_ptr;
		feed(lo_level, 0, 7);
		events++;
		arm(TRIG_FALLING, 6, 1'b1);
		read_buffer(trig, 12);
		foreach (rx_samples[i])
			check_value("falling sample", word_t'(rx_samples[i]), word_t'(sample_t'(lo_level)));
		end_test("falling trigger");

		send_cmd(make_cmd(CMD_DOWNSAMPLE, 8'd2, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0));
		status_reply(32'd9);
		model_ds = 2;
		arm(TRIG_NONE, 8, 1'b0);
		trig = model_ptr;
		feed(0, 1, 32);
		events++;
		arm(TRIG_NONE, 8, 1'b1);
		read_buffer(trig, 16);
		for (int i = 0; i + 1 < rx_samples.size(); i++)
			check_value("sample step", word_t'(int'(rx_samples[i+1]) - int'(rx_samples[i])), 4);
		end_test("downsampling");

		trig_cfg(8'd128, 8'd16, 3, 8'd2);
		ready_random = 1'b1;
		read_buffer(wrap_addr(trig - 3), 10); // look back three samples
		ready_random = 1'b0;
		end_test("readout back-pressure");

		send_cmd(make_cmd(8'h55, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0));
		out_ready = 1'b1;
		quiet     = 1'b1;
		repeat (50) begin
			if (out_valid)
				quiet = 1'b0;
			@(posedge clk);
			#1;
		end
		out_ready = 1'b0;
		assert (quiet)
		else begin
			$display("%0t ns: unknown command produced an output word", $time);
			errors++;
		end
		send_cmd(make_cmd(CMD_INFO, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0));
		status_reply(VERSION_EXP);
		end_test("unknown command");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* sources.f */
logic/scope_pkg.sv
logic/cmd_receiver.sv
logic/cmd_decoder.sv
logic/acq_trigger.sv
logic/sample_buffer.sv
logic/resp_streamer.sv
logic/scope_top.sv
verification/tb_clock.sv
verification/tb_scope.sv
